// File: dv/tb_uart_tasks.svh
////////////////////////////////////////
// UART send tasks, LFSR, program and load helpers
////////////////////////////////////////
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit, cancel code never comes out
task automatic rand_byte(output byte_t b);
    b = '0;
    do begin
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
    end while (b == CMD_CANCEL);
endtask

// Byte that the parser ignores in idle
task automatic rand_idle_byte(output byte_t b, input byte_t avoid);
    do begin
        rand_byte(b);
    end while (b == CMD_PROGRAM || b == CMD_SOFT_RESET || b == avoid);
endtask

////////////////////////////////////////
// Serial frames, LSB first
task automatic send_frame(input byte_t b, input logic stop_bit);
    logic [9:0] bits;
    bits = {stop_bit, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
        @(posedge clk);
        uart_rxd <= bits[i];
        repeat (BIT_CLKS - 1) @(posedge clk);
    end
endtask

task automatic send_uart_byte(input byte_t b);
    send_frame(b, 1'b1);
endtask

task automatic send_uart_bad_stop(input byte_t b);
    send_frame(b, 1'b0);
    @(posedge clk);
    uart_rxd <= 1'b1;  // One idle bit to let the receiver recover
    repeat (BIT_CLKS - 1) @(posedge clk);
endtask

// PROGRAM, address, data, and the model follows
task automatic program_byte(input byte_t addr, input byte_t data);
    send_uart_byte(CMD_PROGRAM);
    send_uart_byte(addr);
    send_uart_byte(data);
    if (int'(addr) < REG_DEPTH_TB) begin
        model[AW'(addr)] = data;
        exp_cfg          = expected_cfg();
    end
endtask

task automatic wait_load_done();
    int n;
    n = 0;
    while (!load_done && n < LOAD_WAIT) begin
        @(posedge clk);
        n++;
    end
    if (load_done) begin
        loads_seen++;
    end else begin
        errors++;
        $display("load_done did not come within %0d cycles", LOAD_WAIT);
    end
    @(posedge clk);  // Let the checks on this edge report
endtask

task automatic run_load();
    @(posedge clk);
    load_start <= 1'b1;
    @(posedge clk);
    load_start <= 1'b0;
    wait_load_done();
endtask

`endif

// File: dv/tb_robot_cfg.sv
////////////////////////////////////////
// Testbench for the configuration receiver
////////////////////////////////////////
`timescale 1ns/10ps

module tb_robot_cfg;
    import robot_cfg_pkg::*;

    localparam int BIT_CLKS        = 16;
    localparam int REG_DEPTH_TB    = 32;
    localparam int AW              = $clog2(REG_DEPTH_TB);
    localparam int LOAD_LATENCY    = 24;
    localparam int LOAD_WAIT       = 40;
    localparam int BYTES_SENT      = 83;  // Frames over all tests
    localparam int LOADS           = 6;
    localparam int WATCHDOG_CYCLES = BYTES_SENT * 10 * BIT_CLKS + LOADS * 30 + 1000;

    logic        clk;
    logic        reset;
    logic        uart_rxd;
    logic        load_start;
    robot_cfg_t  cfg;
    logic        load_done;

    byte_t       model [REG_DEPTH_TB];
    robot_cfg_t  exp_cfg;
    logic [31:0] lfsr;
    logic        in_load;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          loads_seen;

    robot_cfg_top #(
        .CLKS_PER_BIT(BIT_CLKS),
        .REG_DEPTH   (REG_DEPTH_TB)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .uart_rxd   (uart_rxd),
        .load_start (load_start),
        .cfg        (cfg),
        .load_done  (load_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Record from the byte model with little-endian fields
    function automatic robot_cfg_t expected_cfg();
        robot_cfg_t c;
        c.init_x            = {model[3], model[2], model[1], model[0]};
        c.init_y            = {model[7], model[6], model[5], model[4]};
        c.target_x          = {model[11], model[10], model[9], model[8]};
        c.target_y          = {model[15], model[14], model[13], model[12]};
        c.stop_threshold    = {model[17], model[16]};
        c.turn_constant     = {model[19], model[18]};
        c.critical_distance = model[20];
        c.turn_count        = model[21];
        return c;
    endfunction

    `include "tb_uart_tasks.svh"

    ////////////////////////////////////////
    // Checks
    always_ff @(posedge clk or posedge reset) begin
        if (reset) in_load <= 1'b0;
        else if (load_done) in_load <= 1'b0;
        else if (load_start) in_load <= 1'b1;
    end

    a_load_latency: assert property (@(posedge clk) disable iff (reset)
        ($rose(load_start) && !in_load) |-> ##LOAD_LATENCY load_done)
        else begin
            errors++;
            $display("load_done missing %0d cycles after load_start", LOAD_LATENCY);
        end

    a_cfg_match: assert property (@(posedge clk) disable iff (reset)
        load_done |-> (cfg == exp_cfg))
        else begin
            errors++;
            $display("Mismatch cfg: got %h expected %h", cfg, exp_cfg);
        end

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d error(s)", tests_run, name, errors - errs_before);
        end
    endtask

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Tests
    initial begin
        byte_t d;
        int    errs;
        uart_rxd     = 1'b1;
        load_start   = 1'b0;
        reset        = 1'b1;
        lfsr         = 32'hc018;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        loads_seen   = 0;
        for (int i = 0; i < REG_DEPTH_TB; i++) begin
            model[i] = '0;
        end
        exp_cfg = expected_cfg();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        errs = errors;
        assert (!load_done) else begin
            errors++;
            $display("load_done high after reset");
        end
        assert (cfg == '0) else begin
            errors++;
            $display("Mismatch cfg: got %h expected %h", cfg, exp_cfg);
        end
        run_load();
        report_test("reset load", errs);

        errs = errors;
        for (int a = 0; a < CFG_BYTES; a++) begin
            rand_byte(d);
            if (a == 3 || a == 11) d[7] = 1'b1;  // Negative init_x and target_x
            program_byte(8'(a), d);
        end
        run_load();
        report_test("program and load", errs);

        errs = errors;
        rand_idle_byte(d, model[5]);
        send_uart_byte(CMD_PROGRAM);
        send_uart_byte(8'd5);
        send_uart_byte(CMD_CANCEL);
        send_uart_byte(d);
        run_load();
        report_test("cancel", errs);

        errs = errors;
        do begin
            rand_byte(d);
        end while (d == model[0]);
        program_byte(8'd0, d);
        rand_byte(d);
        program_byte(8'd21, d);
        send_uart_byte(CMD_SOFT_RESET);  // load_start stays low
        wait_load_done();
        report_test("soft reset", errs);

        errs = errors;
        do begin
            rand_byte(d);
        end while (d == model[3]);
        program_byte(8'(REG_DEPTH_TB + 3), d);
        run_load();
        report_test("out of range address", errs);

        errs = errors;
        rand_idle_byte(d, model[7]);
        send_uart_bad_stop(CMD_PROGRAM);
        send_uart_byte(8'd7);
        send_uart_byte(d);
        run_load();
        report_test("framing error", errs);

        $display("Tests run %0d, failed %0d, loads %0d of %0d, errors %0d",
                 tests_run, tests_failed, loads_seen, LOADS, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+dv
source/robot_cfg_pkg.sv
source/uart_byte_rx.sv
source/cfg_cmd_parser.sv
source/cfg_byte_ram.sv
source/cfg_loader.sv
source/robot_cfg_top.sv
dv/tb_robot_cfg.sv

// File: run.sh
#!/bin/sh
# Compile and run the configuration receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module tb_robot_cfg \
    -f filelist.f \
    -o sim_tb_robot_cfg

# The log decides the result, so a nonzero simulator exit is not fatal here
./obj_dir/sim_tb_robot_cfg > sim.log 2>&1 || true
cat sim.log

grep -qx "TB PASSED" sim.log

// File: source/cfg_byte_ram.sv
////////////////////////////////////////
// Byte register RAM, one write port, registered read
////////////////////////////////////////
`timescale 1ns/10ps

module cfg_byte_ram #(
    parameter int REG_DEPTH = 32
) (
    input  logic                   clk,
    input  logic                   reset,
    input  robot_cfg_pkg::reg_wr_t wr,
    input  robot_cfg_pkg::byte_t   rd_addr,
    output robot_cfg_pkg::byte_t   rd_data
);
    import robot_cfg_pkg::*;

    localparam int AW = $clog2(REG_DEPTH);

    byte_t mem [REG_DEPTH];
    logic  wr_hit;
    logic  rd_hit;

    // Out-of-range addresses are dropped
    assign wr_hit = wr.en && (int'(wr.addr) < REG_DEPTH);
    assign rd_hit = int'(rd_addr) < REG_DEPTH;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < REG_DEPTH; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (wr_hit) mem[AW'(wr.addr)] <= wr.data;
            rd_data <= rd_hit ? mem[AW'(rd_addr)] : '0;
        end
    end

endmodule

// File: source/cfg_cmd_parser.sv
////////////////////////////////////////
// Command parser, bytes to RAM writes and reload requests
////////////////////////////////////////
`timescale 1ns/10ps

module cfg_cmd_parser (
    input  logic                      clk,
    input  logic                      reset,
    input  robot_cfg_pkg::uart_byte_t rx_byte,
    output robot_cfg_pkg::reg_wr_t    wr,
    output logic                      reload_req
);
    import robot_cfg_pkg::*;

    typedef enum logic [1:0] {
        P_IDLE,
        P_ADDR,
        P_DATA,
        P_WRITE
    } parse_state_t;

    parse_state_t state;
    byte_t        addr_q;
    byte_t        data_q;
    logic         reload_q;
    logic         is_cancel;

    assign is_cancel = (rx_byte.data == CMD_CANCEL);

    ////////////////////////////////////////
    // Sequence FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= P_IDLE;
            reload_q <= 1'b0;
        end else begin
            reload_q <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (rx_byte.valid) begin
                        if (rx_byte.data == CMD_PROGRAM) begin
                            state <= P_ADDR;
                        end else if (rx_byte.data == CMD_SOFT_RESET) begin
                            reload_q <= 1'b1;  // Acts at once, no trailing byte
                        end
                    end
                end
                P_ADDR: begin
                    if (rx_byte.valid) state <= is_cancel ? P_IDLE : P_DATA;
                end
                P_DATA: begin
                    if (rx_byte.valid) state <= is_cancel ? P_IDLE : P_WRITE;
                end
                P_WRITE: state <= P_IDLE;
                default: state <= P_IDLE;
            endcase
        end
    end

    // Address and data latches
    always_ff @(posedge clk) begin
        if (rx_byte.valid && !is_cancel) begin
            if (state == P_ADDR) addr_q <= rx_byte.data;
            if (state == P_DATA) data_q <= rx_byte.data;
        end
    end

    assign wr.en       = (state == P_WRITE);
    assign wr.addr     = addr_q;
    assign wr.data     = data_q;
    assign reload_req  = reload_q;

    a_wr_reload_excl: assert property (@(posedge clk) disable iff (reset)
        !(wr.en && reload_req))
        else $error("Write and reload issued together");

endmodule

// File: source/cfg_loader.sv
////////////////////////////////////////
// Load sequencer, RAM bytes to configuration record
////////////////////////////////////////
`timescale 1ns/10ps

module cfg_loader (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      load_start,
    input  logic                      reload_req,
    output robot_cfg_pkg::byte_t      rd_addr,
    input  robot_cfg_pkg::byte_t      rd_data,
    output robot_cfg_pkg::robot_cfg_t cfg,
    output logic                      load_done
);
    import robot_cfg_pkg::*;

    localparam int CNT_W = $clog2(CFG_BYTES + 1);
    // Count value in the cycle the last byte comes back
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CFG_BYTES);
    localparam int RAW_W = $bits(cfg_raw_t);
    // Trigger to load_done, one per byte plus read latency and output register
    localparam int LOAD_LATENCY = CFG_BYTES + 2;

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic             start;
    cfg_raw_t         shift_q;
    cfg_raw_t         shift_next;

    assign start = !busy && (load_start || reload_req);

    // New byte enters at the top, byte 0 ends up lowest
    assign shift_next = {rd_data, shift_q[RAW_W-1:8]};

    assign rd_addr = byte_t'(cnt);

    ////////////////////////////////////////
    // Sequencer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy      <= 1'b0;
            cnt       <= '0;
            load_done <= 1'b0;
            cfg       <= '0;
        end else begin
            load_done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == LAST_CNT) begin
                    busy      <= 1'b0;
                    load_done <= 1'b1;
                    cfg       <= cfg_from_bytes(shift_next);  // Whole record at once
                end
            end
        end
    end

    // Read data lags the address by one cycle
    always_ff @(posedge clk) begin
        if (busy && cnt != '0) shift_q <= shift_next;
    end

    a_load_latency: assert property (@(posedge clk) disable iff (reset)
        start |-> ##LOAD_LATENCY load_done)
        else $error("load_done missing at fixed latency");

endmodule

// File: source/robot_cfg_pkg.sv
////////////////////////////////////////
// Command codes, field map, record and byte types
////////////////////////////////////////
package robot_cfg_pkg;

    // Command bytes seen in the idle state
    localparam logic [7:0] CMD_CANCEL     = 8'h18;
    localparam logic [7:0] CMD_PROGRAM    = 8'h24;
    localparam logic [7:0] CMD_SOFT_RESET = 8'h11;

    typedef logic [7:0] byte_t;

    typedef struct packed {
        logic  valid;  // One cycle per good frame
        byte_t data;
    } uart_byte_t;

    typedef struct packed {
        logic  en;
        byte_t addr;   // Raw received address, range checked in the RAM
        byte_t data;
    } reg_wr_t;

    typedef struct packed {
        logic signed [31:0] init_x;
        logic signed [31:0] init_y;
        logic signed [31:0] target_x;
        logic signed [31:0] target_y;
        logic [15:0]        stop_threshold;
        logic [15:0]        turn_constant;
        logic [7:0]         critical_distance;
        logic [7:0]         turn_count;
    } robot_cfg_t;

    localparam int CFG_BYTES = $bits(robot_cfg_t) / 8;

    // Byte stream as read from the RAM, byte 0 in the low bits
    typedef logic [CFG_BYTES*8-1:0] cfg_raw_t;

    ////////////////////////////////////////
    // Field map, first byte address of each field
    localparam int INIT_X_OFS            = 0;
    localparam int INIT_Y_OFS            = 4;
    localparam int TARGET_X_OFS          = 8;
    localparam int TARGET_Y_OFS          = 12;
    localparam int STOP_THRESHOLD_OFS    = 16;
    localparam int TURN_CONSTANT_OFS     = 18;
    localparam int CRITICAL_DISTANCE_OFS = 20;
    localparam int TURN_COUNT_OFS        = 21;

    // Little-endian byte stream to record
    function automatic robot_cfg_t cfg_from_bytes(input cfg_raw_t raw);
        robot_cfg_t c;
        c.init_x            = raw[INIT_X_OFS*8 +: 32];
        c.init_y            = raw[INIT_Y_OFS*8 +: 32];
        c.target_x          = raw[TARGET_X_OFS*8 +: 32];
        c.target_y          = raw[TARGET_Y_OFS*8 +: 32];
        c.stop_threshold    = raw[STOP_THRESHOLD_OFS*8 +: 16];
        c.turn_constant     = raw[TURN_CONSTANT_OFS*8 +: 16];
        c.critical_distance = raw[CRITICAL_DISTANCE_OFS*8 +: 8];
        c.turn_count        = raw[TURN_COUNT_OFS*8 +: 8];
        return c;
    endfunction

endpackage

// File: source/robot_cfg_top.sv
////////////////////////////////////////
// Configuration receiver top level
////////////////////////////////////////
`timescale 1ns/10ps

module robot_cfg_top #(
    parameter int CLKS_PER_BIT = 16,
    parameter int REG_DEPTH    = 32
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      uart_rxd,
    input  logic                      load_start,
    output robot_cfg_pkg::robot_cfg_t cfg,
    output logic                      load_done
);
    import robot_cfg_pkg::*;

    uart_byte_t rx_byte;
    reg_wr_t    wr;
    logic       reload_req;
    byte_t      rd_addr;
    byte_t      rd_data;

    // RAM must hold one full record
    if (REG_DEPTH < CFG_BYTES) begin : g_depth_check
        $error("REG_DEPTH too small for the configuration record");
    end

    uart_byte_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_rx (
        .clk     (clk),
        .reset   (reset),
        .rxd     (uart_rxd),
        .rx_byte (rx_byte)
    );

    cfg_cmd_parser u_parser (
        .clk        (clk),
        .reset      (reset),
        .rx_byte    (rx_byte),
        .wr         (wr),
        .reload_req (reload_req)
    );

    cfg_byte_ram #(
        .REG_DEPTH(REG_DEPTH)
    ) u_ram (
        .clk     (clk),
        .reset   (reset),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    cfg_loader u_loader (
        .clk        (clk),
        .reset      (reset),
        .load_start (load_start),
        .reload_req (reload_req),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .cfg        (cfg),
        .load_done  (load_done)
    );

endmodule

// File: source/uart_byte_rx.sv
////////////////////////////////////////
// UART 8N1 byte receiver
////////////////////////////////////////
`timescale 1ns/10ps

module uart_byte_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rxd,
    output robot_cfg_pkg::uart_byte_t rx_byte
);
    import robot_cfg_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_END = CNT_W'((CLKS_PER_BIT - 1) / 2);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_BREAK   // Bad stop bit, wait out the rest of it
    } rx_state_t;

    rx_state_t        state;
    logic             rxd_meta;
    logic             rxd_s;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic             valid_q;
    byte_t            shift_q;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_s    <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_s    <= rxd_meta;
        end
    end

    ////////////////////////////////////////
    // Frame FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rxd_s) state <= RX_START;
                end
                RX_START: begin
                    if (clk_cnt == HALF_END) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rxd_s ? RX_IDLE : RX_DATA;  // Glitch rejected
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == BIT_END) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == BIT_END) begin
                        clk_cnt <= '0;
                        valid_q <= rxd_s;
                        state   <= rxd_s ? RX_IDLE : RX_BREAK;
                    end
                end
                RX_BREAK: begin
                    if (clk_cnt == HALF_END) state <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && clk_cnt == BIT_END) shift_q <= {rxd_s, shift_q[7:1]};
    end

    assign rx_byte.valid = valid_q;
    assign rx_byte.data  = shift_q;

    a_single_valid: assert property (@(posedge clk) disable iff (reset)
        rx_byte.valid |=> !rx_byte.valid)
        else $error("UART valid held for more than one cycle");

endmodule
